//--- hdl/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cache geometry
`define DC_WAYS          2
`define DC_SETS          16
`define DC_LINE_B        8
`define DC_DATA_W        64
`define DC_PADDR_W       32
`define DC_RD_PORTS      2
`define DC_MISS_ENTRIES  4

// l2 tag is {kind, entry index}
`define DC_L2_TAG_W      4
`define DC_L2_KIND_L1D   2'b01

// derived widths
`define DC_WAY_W         ($clog2(`DC_WAYS))
`define DC_SET_W         ($clog2(`DC_SETS))
`define DC_OFS_W         ($clog2(`DC_LINE_B))
`define DC_LINE_ADDR_W   (`DC_PADDR_W - `DC_OFS_W)
`define DC_TAG_W         (`DC_LINE_ADDR_W - `DC_SET_W)
`define DC_MISS_IDX_W    ($clog2(`DC_MISS_ENTRIES))

`endif

//--- hdl/dcache_pkg.sv
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

  // one write into the tag/data array
  typedef struct packed {
    logic                         valid;
    logic [`DC_LINE_ADDR_W-1:0]   line_addr;
    logic [`DC_WAY_W-1:0]         way;
    logic [`DC_DATA_W-1:0]        data;
    logic [`DC_LINE_B-1:0]        be;
  } dc_update_t;

  // s0 read request
  typedef struct packed {
    logic                         valid;
    logic [`DC_PADDR_W-1:0]       paddr;
  } dc_read_req_t;

  // s1 read response
  typedef struct packed {
    logic                         hit;
    logic                         miss;
    logic [`DC_WAY_W-1:0]         hit_way;
    logic [`DC_WAY_W-1:0]         replace_way;
    logic [`DC_DATA_W-1:0]        data;
  } dc_read_resp_t;

  // outstanding line fill
  typedef struct packed {
    logic                         valid;
    logic [`DC_LINE_ADDR_W-1:0]   line_paddr;
    logic [`DC_WAY_W-1:0]         evict_way;
  } miss_entry_t;

endpackage

`default_nettype wire

//--- hdl/dcache_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_array (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset_n,
  input  dcache_pkg::dc_update_t       i_update,
  input  dcache_pkg::dc_read_req_t     i_rd_req [`DC_RD_PORTS],
  output dcache_pkg::dc_read_resp_t    o_rd_resp [`DC_RD_PORTS]
);

  logic [`DC_SETS-1:0]    r_valid  [`DC_WAYS];
  logic [`DC_TAG_W-1:0]   r_tag    [`DC_WAYS][`DC_SETS];
  logic [`DC_DATA_W-1:0]  r_data   [`DC_WAYS][`DC_SETS];
  logic [`DC_WAY_W-1:0]   r_victim [`DC_SETS];

  logic [`DC_SET_W-1:0]   w_upd_set;
  logic [`DC_TAG_W-1:0]   w_upd_tag;
  logic                   w_upd_refill;
  logic [`DC_WAY_W-1:0]   w_victim_next;

  assign w_upd_set    = i_update.line_addr[`DC_SET_W-1:0];
  assign w_upd_tag    = i_update.line_addr[`DC_LINE_ADDR_W-1:`DC_SET_W];
  // full line write means refill
  assign w_upd_refill = i_update.valid & (&i_update.be);
  assign w_victim_next = (int'(r_victim[w_upd_set]) == `DC_WAYS - 1) ? '0 :
                         r_victim[w_upd_set] + 1'b1;

  // ----------------------------------------
  // read ports
  // ----------------------------------------
  for (genvar p = 0; p < `DC_RD_PORTS; p++) begin : g_port
    logic [`DC_SET_W-1:0]  w_set;
    logic [`DC_TAG_W-1:0]  w_tag;
    logic                  w_hit;
    logic [`DC_WAY_W-1:0]  w_hit_way;
    logic [`DC_DATA_W-1:0] w_hit_data;
    logic [`DC_WAY_W-1:0]  w_repl_way;

    logic                  r_s1_hit;
    logic                  r_s1_miss;
    logic [`DC_WAY_W-1:0]  r_s1_hit_way;
    logic [`DC_WAY_W-1:0]  r_s1_repl_way;
    logic [`DC_DATA_W-1:0] r_s1_data;

    assign w_set = i_rd_req[p].paddr[`DC_OFS_W +: `DC_SET_W];
    assign w_tag = i_rd_req[p].paddr[`DC_PADDR_W-1 -: `DC_TAG_W];

    // compare all ways, forwarding a same-edge update
    always_comb begin
      logic                  upd_match;
      logic                  way_valid;
      logic [`DC_TAG_W-1:0]  way_tag;
      logic [`DC_DATA_W-1:0] way_data;
      w_hit      = 1'b0;
      w_hit_way  = '0;
      w_hit_data = '0;
      upd_match  = 1'b0;
      way_valid  = 1'b0;
      way_tag    = '0;
      way_data   = '0;
      for (int w = 0; w < `DC_WAYS; w++) begin
        upd_match = i_update.valid && (w_upd_set == w_set) &&
                    (int'(i_update.way) == w);
        way_valid = r_valid[w][w_set] | upd_match;
        way_tag   = upd_match ? w_upd_tag : r_tag[w][w_set];
        way_data  = r_data[w][w_set];
        for (int b = 0; b < `DC_LINE_B; b++) begin
          if (upd_match && i_update.be[b]) begin
            way_data[b*8 +: 8] = i_update.data[b*8 +: 8];
          end
        end
        if (way_valid && (way_tag == w_tag)) begin
          w_hit      = 1'b1;
          w_hit_way  = w[`DC_WAY_W-1:0];
          w_hit_data = way_data;
        end
      end
    end

    // victim as it will be after this edge
    assign w_repl_way = (w_upd_refill && (w_upd_set == w_set)) ? w_victim_next :
                        r_victim[w_set];

    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_s1_hit  <= 1'b0;
        r_s1_miss <= 1'b0;
      end else begin
        r_s1_hit  <= i_rd_req[p].valid & w_hit;
        r_s1_miss <= i_rd_req[p].valid & ~w_hit;
      end
    end

    always_ff @(posedge i_clk) begin
      r_s1_hit_way  <= w_hit_way;
      r_s1_repl_way <= w_repl_way;
      r_s1_data     <= w_hit_data;
    end

    assign o_rd_resp[p].hit         = r_s1_hit;
    assign o_rd_resp[p].miss        = r_s1_miss;
    assign o_rd_resp[p].hit_way     = r_s1_hit_way;
    assign o_rd_resp[p].replace_way = r_s1_repl_way;
    assign o_rd_resp[p].data        = r_s1_data;
  end

  // ----------------------------------------
  // update port
  // ----------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        r_valid[w] <= '0;
      end
      for (int s = 0; s < `DC_SETS; s++) begin
        r_victim[s] <= '0;
      end
    end else begin
      if (i_update.valid) begin
        r_valid[i_update.way][w_upd_set] <= 1'b1;
      end
      if (w_upd_refill) begin
        r_victim[w_upd_set] <= w_victim_next;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_update.valid) begin
      r_tag[i_update.way][w_upd_set] <= w_upd_tag;
      for (int b = 0; b < `DC_LINE_B; b++) begin
        if (i_update.be[b]) begin
          r_data[i_update.way][w_upd_set][b*8 +: 8] <= i_update.data[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/miss_entry_table.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defs.svh"

module miss_entry_table (
  input  wire logic                        i_clk,
  input  wire logic                        i_reset_n,
  input  dcache_pkg::dc_read_req_t         i_rd_req  [`DC_RD_PORTS],
  input  dcache_pkg::dc_read_resp_t        i_rd_resp [`DC_RD_PORTS],
  input  wire logic                        i_search_valid,
  input  wire logic [`DC_MISS_IDX_W-1:0]   i_search_index,
  input  wire logic                        i_free_valid,
  input  wire logic [`DC_MISS_IDX_W-1:0]   i_free_index,
  output dcache_pkg::miss_entry_t          o_search_entry,
  output logic                             o_l2_req_valid,
  output logic [`DC_PADDR_W-1:0]           o_l2_req_paddr,
  output logic [`DC_L2_TAG_W-1:0]          o_l2_req_tag
);

  localparam int IDX_W = `DC_MISS_IDX_W;

  dcache_pkg::miss_entry_t      r_entry [`DC_MISS_ENTRIES];
  logic [`DC_LINE_ADDR_W-1:0]   r_s1_line [`DC_RD_PORTS];

  logic                         w_alloc_req;
  logic [`DC_LINE_ADDR_W-1:0]   w_alloc_line;
  logic [`DC_WAY_W-1:0]         w_alloc_way;
  logic                         w_free_found;
  logic [IDX_W-1:0]             w_free_idx;
  logic                         w_alloc;

  logic                         r_l2_req_valid;
  logic [`DC_LINE_ADDR_W-1:0]   r_l2_req_line;
  logic [IDX_W-1:0]             r_l2_req_idx;

  // line address follows the read into s1
  always_ff @(posedge i_clk) begin
    for (int p = 0; p < `DC_RD_PORTS; p++) begin
      if (i_rd_req[p].valid) begin
        r_s1_line[p] <= i_rd_req[p].paddr[`DC_PADDR_W-1:`DC_OFS_W];
      end
    end
  end

  // lowest missing port whose line is not already pending
  always_comb begin
    logic dup;
    dup          = 1'b0;
    w_alloc_req  = 1'b0;
    w_alloc_line = '0;
    w_alloc_way  = '0;
    for (int p = `DC_RD_PORTS - 1; p >= 0; p--) begin
      dup = 1'b0;
      for (int e = 0; e < `DC_MISS_ENTRIES; e++) begin
        if (r_entry[e].valid && (r_entry[e].line_paddr == r_s1_line[p])) begin
          dup = 1'b1;
        end
      end
      if (i_rd_resp[p].miss && !dup) begin
        w_alloc_req  = 1'b1;
        w_alloc_line = r_s1_line[p];
        w_alloc_way  = i_rd_resp[p].replace_way;
      end
    end
  end

  // lowest free entry
  // an entry being freed counts as free
  always_comb begin
    w_free_found = 1'b0;
    w_free_idx   = '0;
    for (int e = `DC_MISS_ENTRIES - 1; e >= 0; e--) begin
      if (!r_entry[e].valid || (i_free_valid && (int'(i_free_index) == e))) begin
        w_free_found = 1'b1;
        w_free_idx   = IDX_W'(e);
      end
    end
  end

  assign w_alloc = w_alloc_req & w_free_found;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int e = 0; e < `DC_MISS_ENTRIES; e++) begin
        r_entry[e] <= '0;
      end
      r_l2_req_valid <= 1'b0;
    end else begin
      for (int e = 0; e < `DC_MISS_ENTRIES; e++) begin
        if (w_alloc && (int'(w_free_idx) == e)) begin
          r_entry[e].valid      <= 1'b1;
          r_entry[e].line_paddr <= w_alloc_line;
          r_entry[e].evict_way  <= w_alloc_way;
        end else if (i_free_valid && (int'(i_free_index) == e)) begin
          r_entry[e].valid <= 1'b0;
        end
      end
      r_l2_req_valid <= w_alloc;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_alloc) begin
      r_l2_req_line <= w_alloc_line;
      r_l2_req_idx  <= w_free_idx;
    end
  end

  assign o_l2_req_valid = r_l2_req_valid;
  assign o_l2_req_paddr = {r_l2_req_line, {`DC_OFS_W{1'b0}}};
  assign o_l2_req_tag   = {`DC_L2_KIND_L1D, r_l2_req_idx};

  assign o_search_entry = i_search_valid ? r_entry[i_search_index] : '0;

endmodule

`default_nettype wire

//--- hdl/refill_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defs.svh"

module refill_ctrl (
  input  wire logic                        i_clk,
  input  wire logic                        i_reset_n,
  input  wire logic                        i_l2_resp_valid,
  input  wire logic [`DC_L2_TAG_W-1:0]     i_l2_resp_tag,
  input  wire logic [`DC_DATA_W-1:0]       i_l2_resp_data,
  input  dcache_pkg::miss_entry_t          i_search_entry,
  input  wire logic                        i_merge_valid,
  input  wire logic [`DC_LINE_B-1:0]       i_merge_be,
  input  wire logic [`DC_DATA_W-1:0]       i_merge_data,
  input  wire logic                        i_wr_valid,
  input  wire logic [`DC_PADDR_W-1:0]      i_wr_paddr,
  input  wire logic [`DC_WAY_W-1:0]        i_wr_way,
  input  wire logic [`DC_DATA_W-1:0]       i_wr_data,
  input  wire logic [`DC_LINE_B-1:0]       i_wr_be,
  output logic                             o_search_valid,
  output logic [`DC_MISS_IDX_W-1:0]        o_search_index,
  output logic                             o_free_valid,
  output logic [`DC_MISS_IDX_W-1:0]        o_free_index,
  output dcache_pkg::dc_update_t           o_update,
  output logic                             o_wr_conflict
);

  logic                         w_resp_ours;

  logic                         r_rp1_valid;
  logic [`DC_MISS_IDX_W-1:0]    r_rp1_index;
  logic [`DC_DATA_W-1:0]        r_rp1_data;

  logic                         r_rp2_valid;
  logic [`DC_MISS_IDX_W-1:0]    r_rp2_index;
  dcache_pkg::miss_entry_t      r_rp2_entry;
  logic [`DC_DATA_W-1:0]        r_rp2_data;
  logic [`DC_DATA_W-1:0]        w_rp2_merged;

  // ----------------------------------------
  // rp1: capture response
  // ----------------------------------------
  assign w_resp_ours = i_l2_resp_valid &
                       (i_l2_resp_tag[`DC_L2_TAG_W-1 -: 2] == `DC_L2_KIND_L1D);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rp1_valid <= 1'b0;
      r_rp2_valid <= 1'b0;
    end else begin
      r_rp1_valid <= w_resp_ours;
      // stale tag with no pending entry is dropped
      r_rp2_valid <= r_rp1_valid & i_search_entry.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_rp1_index <= i_l2_resp_tag[`DC_MISS_IDX_W-1:0];
    r_rp1_data  <= i_l2_resp_data;
    r_rp2_index <= r_rp1_index;
    r_rp2_entry <= i_search_entry;
    r_rp2_data  <= r_rp1_data;
  end

  assign o_search_valid = r_rp1_valid;
  assign o_search_index = r_rp1_index;

  // ----------------------------------------
  // rp2: merge and write
  // ----------------------------------------
  always_comb begin
    w_rp2_merged = r_rp2_data;
    for (int b = 0; b < `DC_LINE_B; b++) begin
      if (i_merge_valid && i_merge_be[b]) begin
        w_rp2_merged[b*8 +: 8] = i_merge_data[b*8 +: 8];
      end
    end
  end

  // refill owns the update port and the store waits
  always_comb begin
    o_update.valid = r_rp2_valid | i_wr_valid;
    if (r_rp2_valid) begin
      o_update.line_addr = r_rp2_entry.line_paddr;
      o_update.way       = r_rp2_entry.evict_way;
      o_update.data      = w_rp2_merged;
      o_update.be        = '1;
    end else begin
      o_update.line_addr = i_wr_paddr[`DC_PADDR_W-1:`DC_OFS_W];
      o_update.way       = i_wr_way;
      o_update.data      = i_wr_data;
      o_update.be        = i_wr_be;
    end
  end

  assign o_wr_conflict = r_rp2_valid & i_wr_valid;

  assign o_free_valid = r_rp2_valid;
  assign o_free_index = r_rp2_index;

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_top (
  input  wire logic                        i_clk,
  input  wire logic                        i_reset_n,

  // read ports
  input  wire logic                        i_rd_valid   [`DC_RD_PORTS],
  input  wire logic [`DC_PADDR_W-1:0]      i_rd_paddr   [`DC_RD_PORTS],
  output logic                             o_rd_hit     [`DC_RD_PORTS],
  output logic                             o_rd_miss    [`DC_RD_PORTS],
  output logic [`DC_WAY_W-1:0]             o_rd_hit_way [`DC_RD_PORTS],
  output logic [`DC_DATA_W-1:0]            o_rd_data    [`DC_RD_PORTS],

  // store port
  input  wire logic                        i_wr_valid,
  input  wire logic [`DC_PADDR_W-1:0]      i_wr_paddr,
  input  wire logic [`DC_WAY_W-1:0]        i_wr_way,
  input  wire logic [`DC_DATA_W-1:0]       i_wr_data,
  input  wire logic [`DC_LINE_B-1:0]       i_wr_be,
  output logic                             o_wr_conflict,

  // merge port
  input  wire logic                        i_merge_valid,
  input  wire logic [`DC_LINE_B-1:0]       i_merge_be,
  input  wire logic [`DC_DATA_W-1:0]       i_merge_data,

  // l2 response and request
  input  wire logic                        i_l2_resp_valid,
  input  wire logic [`DC_L2_TAG_W-1:0]     i_l2_resp_tag,
  input  wire logic [`DC_DATA_W-1:0]       i_l2_resp_data,
  output logic                             o_l2_req_valid,
  output logic [`DC_PADDR_W-1:0]           o_l2_req_paddr,
  output logic [`DC_L2_TAG_W-1:0]          o_l2_req_tag
);

  dcache_pkg::dc_update_t       w_update;
  dcache_pkg::dc_read_req_t     w_rd_req  [`DC_RD_PORTS];
  dcache_pkg::dc_read_resp_t    w_rd_resp [`DC_RD_PORTS];
  dcache_pkg::miss_entry_t      w_search_entry;
  logic                         w_search_valid;
  logic [`DC_MISS_IDX_W-1:0]    w_search_index;
  logic                         w_free_valid;
  logic [`DC_MISS_IDX_W-1:0]    w_free_index;

  // flatten per-port structs
  for (genvar p = 0; p < `DC_RD_PORTS; p++) begin : g_port
    assign w_rd_req[p].valid = i_rd_valid[p];
    assign w_rd_req[p].paddr = i_rd_paddr[p];
    assign o_rd_hit[p]       = w_rd_resp[p].hit;
    assign o_rd_miss[p]      = w_rd_resp[p].miss;
    assign o_rd_hit_way[p]   = w_rd_resp[p].hit_way;
    assign o_rd_data[p]      = w_rd_resp[p].data;
  end

  dcache_array u_array (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_update  (w_update),
    .i_rd_req  (w_rd_req),
    .o_rd_resp (w_rd_resp)
  );

  miss_entry_table u_met (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_rd_req       (w_rd_req),
    .i_rd_resp      (w_rd_resp),
    .i_search_valid (w_search_valid),
    .i_search_index (w_search_index),
    .i_free_valid   (w_free_valid),
    .i_free_index   (w_free_index),
    .o_search_entry (w_search_entry),
    .o_l2_req_valid (o_l2_req_valid),
    .o_l2_req_paddr (o_l2_req_paddr),
    .o_l2_req_tag   (o_l2_req_tag)
  );

  refill_ctrl u_refill (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_l2_resp_valid (i_l2_resp_valid),
    .i_l2_resp_tag   (i_l2_resp_tag),
    .i_l2_resp_data  (i_l2_resp_data),
    .i_search_entry  (w_search_entry),
    .i_merge_valid   (i_merge_valid),
    .i_merge_be      (i_merge_be),
    .i_merge_data    (i_merge_data),
    .i_wr_valid      (i_wr_valid),
    .i_wr_paddr      (i_wr_paddr),
    .i_wr_way        (i_wr_way),
    .i_wr_data       (i_wr_data),
    .i_wr_be         (i_wr_be),
    .o_search_valid  (w_search_valid),
    .o_search_index  (w_search_index),
    .o_free_valid    (w_free_valid),
    .o_free_index    (w_free_index),
    .o_update        (w_update),
    .o_wr_conflict   (o_wr_conflict)
  );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // release on a falling edge away from the active edge
  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- test/tb_dcache.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defs.svh"

module tb_dcache;

  localparam int NP             = `DC_RD_PORTS;
  localparam int NE             = `DC_MISS_ENTRIES;
  localparam int POOL_N         = 24;
  localparam int P1_CYCLES      = 12;
  localparam int P2_CYCLES      = 600;
  localparam int TEST_CYCLES    = 10 + P1_CYCLES + P2_CYCLES + POOL_N + 100;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + 2000;

  logic                     clk;
  logic                     reset_n;
  logic                     rd_valid   [NP];
  logic [`DC_PADDR_W-1:0]   rd_paddr   [NP];
  logic                     rd_hit     [NP];
  logic                     rd_miss    [NP];
  logic [`DC_WAY_W-1:0]     rd_hit_way [NP];
  logic [`DC_DATA_W-1:0]    rd_data    [NP];
  logic                     wr_valid;
  logic [`DC_PADDR_W-1:0]   wr_paddr;
  logic [`DC_WAY_W-1:0]     wr_way;
  logic [`DC_DATA_W-1:0]    wr_data;
  logic [`DC_LINE_B-1:0]    wr_be;
  logic                     wr_conflict;
  logic                     merge_valid;
  logic [`DC_LINE_B-1:0]    merge_be;
  logic [`DC_DATA_W-1:0]    merge_data;
  logic                     l2_resp_valid;
  logic [`DC_L2_TAG_W-1:0]  l2_resp_tag;
  logic [`DC_DATA_W-1:0]    l2_resp_data;
  logic                     l2_req_valid;
  logic [`DC_PADDR_W-1:0]   l2_req_paddr;
  logic [`DC_L2_TAG_W-1:0]  l2_req_tag;

  // reference model keyed by line address
  logic [63:0] m_data [int];
  int          m_way  [int];
  int          occ    [`DC_SETS * `DC_WAYS];
  int          victim [`DC_SETS];
  bit          pend_valid [NE];
  int          pend_line  [NE];
  int          pend_way   [NE];
  int          sch_at [$];
  int          sch_idx [$];
  int          rq_idx [$];
  int          rq_due [$];
  int          pool [POOL_N];

  bit          rsp_en;
  bit          nxt_v [NP];
  int          nxt_line [NP];
  bit          last_v [NP];
  int          last_line [NP];
  bit          last_hit [NP];
  int          last_way [NP];
  logic [63:0] last_data [NP];
  int          last_pred [NP];
  bit          prev_v [NP];
  int          prev_line [NP];
  int          prev_pred [NP];
  bit          st_active;
  bit          st_retry;
  int          st_line;
  int          st_way;
  logic [63:0] st_data;
  logic [7:0]  st_be;
  bit          exp_conflict;

  int cyc = 0;
  int last_rsp_cyc = -10;
  int errors;
  int checks;
  int req_count;
  int hit_count;
  int conflict_count;
  int retry_ok;
  int merge_count;
  int b2b_count;
  int bad_kind_count;

  tb_clock #(.PERIOD(20), .RESET_CYCLES(10)) u_clock (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  dcache_top i_dut (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_rd_valid (rd_valid), .i_rd_paddr (rd_paddr),
    .o_rd_hit (rd_hit), .o_rd_miss (rd_miss),
    .o_rd_hit_way (rd_hit_way), .o_rd_data (rd_data),
    .i_wr_valid (wr_valid), .i_wr_paddr (wr_paddr), .i_wr_way (wr_way),
    .i_wr_data (wr_data), .i_wr_be (wr_be), .o_wr_conflict (wr_conflict),
    .i_merge_valid (merge_valid), .i_merge_be (merge_be), .i_merge_data (merge_data),
    .i_l2_resp_valid (l2_resp_valid), .i_l2_resp_tag (l2_resp_tag),
    .i_l2_resp_data (l2_resp_data),
    .o_l2_req_valid (l2_req_valid), .o_l2_req_paddr (l2_req_paddr),
    .o_l2_req_tag (l2_req_tag)
  );

  always @(posedge clk) cyc <= cyc + 1;

  // l2 fill data as a function of the line
  function automatic logic [63:0] line_pattern(input int ln);
    return {32'(ln) ^ 32'hA5C3_0F17, 32'(ln) * 32'h9E37_79B9};
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] base,
                                              input logic [63:0] nd,
                                              input logic [7:0]  be);
    logic [63:0] r;
    r = base;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) r[b*8 +: 8] = nd[b*8 +: 8];
    end
    return r;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("** Error [%s] cycle %0d: expected %h, actual %h", name, cyc, exp, act);
    end
  endtask

  task automatic expect_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Failure at cycle %0d: %s", cyc, what);
    end
  endtask

  // ----------------------------------------
  // output sampling
  // ----------------------------------------
  task automatic sample_outputs();
    int ln;
    int idx;
    int dups;
    bit found;
    if (l2_req_valid === 1'b1) begin
      ln    = int'(l2_req_paddr >> `DC_OFS_W);
      idx   = int'(l2_req_tag[`DC_MISS_IDX_W-1:0]);
      dups  = 0;
      found = 1'b0;
      req_count++;
      compare_value("req_kind", 64'(`DC_L2_KIND_L1D), 64'(l2_req_tag[3:2]));
      compare_value("req_offset", 64'(0), 64'(l2_req_paddr[`DC_OFS_W-1:0]));
      expect_true(!pend_valid[idx], "refill request reuses a busy entry index");
      for (int e = 0; e < NE; e++) begin
        if (pend_valid[e] && pend_line[e] == ln) dups++;
      end
      expect_true(dups == 0, "second refill request for a line already pending");
      // victim was fixed when the missing read was sampled
      for (int p = NP - 1; p >= 0; p--) begin
        if (prev_v[p] && prev_line[p] == ln) begin
          found         = 1'b1;
          pend_way[idx] = prev_pred[p];
        end
      end
      expect_true(found, "refill request for a line that no port read");
      pend_valid[idx] = 1'b1;
      pend_line[idx]  = ln;
      rq_idx.push_back(idx);
      rq_due.push_back(cyc + 2 + int'($urandom % 9));
    end
    for (int p = 0; p < NP; p++) begin
      if (last_v[p]) begin
        compare_value($sformatf("rd%0d_hit", p), 64'(last_hit[p]), 64'(rd_hit[p]));
        compare_value($sformatf("rd%0d_miss", p), 64'(!last_hit[p]), 64'(rd_miss[p]));
        if (last_hit[p]) begin
          compare_value($sformatf("rd%0d_way", p), 64'(last_way[p]), 64'(rd_hit_way[p]));
          compare_value($sformatf("rd%0d_data", p), last_data[p], rd_data[p]);
          if (rd_hit[p] === 1'b1) hit_count++;
        end
      end
      prev_v[p]    = last_v[p];
      prev_line[p] = last_line[p];
      prev_pred[p] = last_pred[p];
      last_v[p]    = 1'b0;
    end
  endtask

  // ----------------------------------------
  // l2 responder and refill model
  // ----------------------------------------
  task automatic answer_l2();
    int sel;
    int idx;
    l2_resp_valid = 1'b0;
    l2_resp_tag   = '0;
    l2_resp_data  = '0;
    sel = -1;
    for (int i = rq_idx.size() - 1; i >= 0; i--) begin
      if (rq_due[i] <= cyc) sel = i;
    end
    if (!rsp_en || sel < 0) return;
    idx = rq_idx[sel];
    l2_resp_valid = 1'b1;
    if ($urandom % 8 == 0) begin
      // foreign kind on a live index
      // the real answer follows later
      l2_resp_tag  = {2'b10, 2'(idx)};
      l2_resp_data = ~line_pattern(pend_line[idx]);
      bad_kind_count++;
    end else begin
      l2_resp_tag  = {`DC_L2_KIND_L1D, 2'(idx)};
      l2_resp_data = line_pattern(pend_line[idx]);
      sch_at.push_back(cyc + 3);
      sch_idx.push_back(idx);
      if (last_rsp_cyc == cyc - 1) b2b_count++;
      last_rsp_cyc = cyc;
      rq_idx.delete(sel);
      rq_due.delete(sel);
    end
  endtask

  // refill lands on the coming edge
  task automatic apply_refill(output bit now);
    int idx;
    int ln;
    int w;
    int s;
    int old;
    logic [63:0] d;
    now         = 1'b0;
    merge_valid = 1'b0;
    merge_be    = '0;
    merge_data  = '0;
    if (sch_at.size() > 0 && sch_at[0] == cyc + 1) begin
      now = 1'b1;
      idx = sch_idx.pop_front();
      void'(sch_at.pop_front());
      ln  = pend_line[idx];
      w   = pend_way[idx];
      s   = ln % `DC_SETS;
      d   = line_pattern(ln);
      if ($urandom % 2 == 0) begin
        merge_valid = 1'b1;
        merge_be    = 8'($urandom);
        merge_data  = {$urandom, $urandom};
        d = merge_bytes(d, merge_data, merge_be);
        merge_count++;
      end
      old = occ[s * `DC_WAYS + w];
      if (old >= 0) begin
        m_data.delete(old);
        m_way.delete(old);
      end
      occ[s * `DC_WAYS + w] = ln;
      m_data[ln] = d;
      m_way[ln]  = w;
      victim[s]  = (victim[s] + 1) % `DC_WAYS;
      pend_valid[idx] = 1'b0;
    end
  endtask

  // ----------------------------------------
  // stores and reads
  // ----------------------------------------
  task automatic present_store(input bit en, input bit now);
    int ln;
    wr_valid = 1'b0;
    wr_paddr = '0;
    wr_way   = '0;
    wr_data  = '0;
    wr_be    = '0;
    // a retry is dropped once its line was evicted
    if (st_active && !(m_way.exists(st_line) && m_way[st_line] == st_way)) begin
      st_active = 1'b0;
    end
    if (!st_active && en && ($urandom % (now ? 2 : 6) == 0)) begin
      ln = pool[$urandom % POOL_N];
      if (m_way.exists(ln)) begin
        st_active = 1'b1;
        st_retry  = 1'b0;
        st_line   = ln;
        st_way    = m_way[ln];
        st_data   = {$urandom, $urandom};
        st_be     = 8'(1 + $urandom % 254);
      end
    end
    if (st_active) begin
      wr_valid = 1'b1;
      wr_paddr = 32'(st_line) << `DC_OFS_W;
      wr_way   = st_way[`DC_WAY_W-1:0];
      wr_data  = st_data;
      wr_be    = st_be;
      if (now) begin
        conflict_count++;
        st_retry = 1'b1;
      end else begin
        m_data[st_line] = merge_bytes(m_data[st_line], st_data, st_be);
        if (st_retry) retry_ok++;
        st_active = 1'b0;
      end
    end
    exp_conflict = wr_valid & now;
  endtask

  task automatic issue_reads();
    int ln;
    for (int p = 0; p < NP; p++) begin
      ln           = nxt_line[p];
      rd_valid[p]  = nxt_v[p];
      rd_paddr[p]  = (32'(ln) << `DC_OFS_W) | 32'($urandom % 8);
      last_v[p]    = nxt_v[p];
      last_line[p] = ln;
      last_hit[p]  = m_way.exists(ln);
      last_way[p]  = 0;
      last_data[p] = '0;
      if (last_hit[p]) begin
        last_way[p]  = m_way[ln];
        last_data[p] = m_data[ln];
      end
      last_pred[p] = victim[ln % `DC_SETS];
    end
  endtask

  task automatic run_cycle(input bit st_en);
    bit now;
    @(negedge clk);
    sample_outputs();
    answer_l2();
    apply_refill(now);
    present_store(st_en, now);
    issue_reads();
    #2;
    compare_value("wr_conflict", 64'(exp_conflict), 64'(wr_conflict));
  endtask

  task automatic wait_idle();
    bit busy;
    for (int p = 0; p < NP; p++) nxt_v[p] = 1'b0;
    repeat (3) run_cycle(1'b0);
    busy = 1'b1;
    while (busy) begin
      busy = (rq_idx.size() > 0) || (sch_at.size() > 0) || st_active;
      for (int e = 0; e < NE; e++) busy = busy | pend_valid[e];
      if (busy) run_cycle(1'b0);
    end
  endtask

  // watchdog
  initial begin
    #(TIMEOUT_CYCLES * 20);
    $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    void'($urandom(25));
    wr_valid = 1'b0;
    wr_paddr = '0;
    wr_way = '0;
    wr_data = '0;
    wr_be = '0;
    merge_valid = 1'b0;
    merge_be = '0;
    merge_data = '0;
    l2_resp_valid = 1'b0;
    l2_resp_tag = '0;
    l2_resp_data = '0;
    for (int p = 0; p < NP; p++) begin
      rd_valid[p] = 1'b0;
      rd_paddr[p] = '0;
    end
    for (int i = 0; i < `DC_SETS * `DC_WAYS; i++) occ[i] = -1;
    for (int s = 0; s < `DC_SETS; s++) victim[s] = 0;
    // 24 lines on sets 0..3 with tags 1..6
    for (int i = 0; i < POOL_N; i++) pool[i] = ((i / 4 + 1) << `DC_SET_W) | (i % 4);

    wait (reset_n === 1'b1);
    expect_true(l2_req_valid === 1'b0, "refill request active after reset");
    expect_true(wr_conflict === 1'b0, "store conflict active after reset");
    for (int p = 0; p < NP; p++) expect_true(rd_hit[p] === 1'b0, "read hit after reset");

    // cold cache with the responder held off until the table fills
    rsp_en = 1'b0;
    for (int k = 0; k < 8; k++) begin
      nxt_v[0] = 1'b1;
      nxt_v[1] = 1'b1;
      nxt_line[0] = pool[k];
      nxt_line[1] = pool[(k > 0) ? k - 1 : 0];
      run_cycle(1'b0);
    end
    for (int p = 0; p < NP; p++) nxt_v[p] = 1'b0;
    repeat (P1_CYCLES - 8) run_cycle(1'b0);
    compare_value("alloc_count", 64'(NE), 64'(req_count));

    // mixed random traffic
    rsp_en = 1'b1;
    for (int c = 0; c < P2_CYCLES; c++) begin
      for (int p = 0; p < NP; p++) begin
        nxt_v[p]    = ($urandom % 4 != 0);
        nxt_line[p] = pool[$urandom % POOL_N];
      end
      run_cycle(1'b1);
    end
    wait_idle();

    // sweep of the whole pool
    for (int i = 0; i < POOL_N; i++) begin
      nxt_v[0] = 1'b1;
      nxt_v[1] = 1'b1;
      nxt_line[0] = pool[i];
      nxt_line[1] = pool[POOL_N - 1 - i];
      run_cycle(1'b0);
    end
    wait_idle();

    expect_true(hit_count > 0, "no read ever hit");
    expect_true(conflict_count > 0, "no store met a refill write");
    expect_true(retry_ok > 0, "no refused store was retried successfully");
    expect_true(merge_count > 0, "no refill carried merged store bytes");
    expect_true(b2b_count > 0, "no two refill responses came on consecutive cycles");
    expect_true(bad_kind_count > 0, "no response with a foreign kind was sent");
    expect_true(req_count > NE, "no miss entry was reused");

    $display("Summary: %0d checks, %0d errors, %0d requests, %0d hits, %0d conflicts",
             checks, errors, req_count, hit_count, conflict_count);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_array.sv
hdl/miss_entry_table.sv
hdl/refill_ctrl.sv
hdl/dcache_top.sv
test/tb_clock.sv
test/tb_dcache.sv

//--- Makefile
TOP := tb_dcache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module dcache_top -f flist.f
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
